// ==== verilog.f ====
source/fpalu_pkg.sv
source/pipe_reg.sv
source/add_align.sv
source/booth_mul.sv
source/shared_adder.sv
source/normalize.sv
source/fpalu_top.sv
bench/fpalu_tb.sv

// ==== bench/fpalu_trace.txt ====
# name op a b y_expected, all fields but name in hex; op 0 is add, 1 is mul
# FP29i word is {sign[28], exp[27:22], man[21:0]}; mul reads exp[26:22] and man[9:0]
add_equal_exp 0 0A200000 0A200000 0A600000
add_align_trunc 0 0A300000 09412345 0A302468
add_carry_norm 0 053FFFFF 04FFFFFF 056FFFFF
add_unnorm_left 0 07800100 07800300 04E00000
add_b_leads 0 02A00000 03100000 02F00000
add_shift_21 0 0A600000 053FFFFF 0A600001
add_shift_22 0 0AA00000 053FFFFF 0AA00000
add_both_neg 0 15100000 15100000 15200000
sub_larger_lead 0 0A300000 19E00000 0A200000
sub_sign_flip 0 07900000 17B00000 17A00000
sub_cancel 0 166ABCDE 066ABCDE 00000000
sub_norm_left 0 0B600000 1B5FFF00 08200000
sub_trunc 0 18680000 07C00007 1867FFFF
sub_b_lead_neg 0 0A3FFFFF 1A600000 15200000
bypass_a_survives 0 13000ABC 0C800000 13000ABC
bypass_b_survives 0 01400000 10C01234 10C01234
bypass_lead_kept 0 0B0F0F0F 10800000 0B0F0F0F
mul_one_one 1 03C00000 03C00000 07E00000
mul_normal 1 04000200 13800300 182A0000
mul_all_ones 1 150003FF 128003FF 083FF001
mul_denorm 1 00000001 03C00155 01EAA800
mul_both_denorm 1 100003FF 00000200 107FF000
mul_zero 1 00000000 14400123 00000000
mul_upper_ignored 1 0BFFFC00 03C00100 07E80000

// ==== bench/fpalu_tb.sv ====
`timescale 1ns/100ps

module fpalu_tb;

	localparam int  CLK_PERIOD   = 4;
	localparam int  RESET_CYCLES = 5;
	localparam int  LATENCY      = 5;  // Issue cycle to out_valid
	localparam time DRIVE_DLY    = 1;
	localparam      TRACE_FILE   = "bench/fpalu_trace.txt";

	logic               clk;
	logic               rst_n;
	logic               in_valid;
	fpalu_pkg::alu_op_e op;
	fpalu_pkg::fp29_t   a;
	fpalu_pkg::fp29_t   b;
	logic               out_valid;
	fpalu_pkg::fp29_t   y;

	// Trace contents, one entry per operation
	string              trace_name[$];
	fpalu_pkg::alu_op_e trace_op[$];
	fpalu_pkg::fp29_t   trace_a[$];
	fpalu_pkg::fp29_t   trace_b[$];
	fpalu_pkg::fp29_t   trace_y[$];

	// In-flight expectations, oldest first
	string              exp_name_q[$];
	fpalu_pkg::fp29_t   exp_y_q[$];
	int                 exp_cycle_q[$];

	integer             seed = 32'he2af;
	int                 cycle = 0;
	int                 n_lines = 0;
	int                 gap;
	int                 result_count = 0;
	int                 mismatch_count = 0;
	int                 other_errors = 0;
	bit                 trace_loaded = 1'b0;
	bit                 loaded;
	string              got_name;
	fpalu_pkg::fp29_t   want_y;
	int                 issued_at;

	fpalu_top i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.op       (op),
		.a        (a),
		.b        (b),
		.out_valid(out_valid),
		.y        (y)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;  // Edge count, read at drive time and negedge

	task automatic check_result(input string name, input fpalu_pkg::fp29_t want,
			input fpalu_pkg::fp29_t got);
		if (got !== want) begin
			$display("MISMATCH %s: expected %h, actual %h", name, want, got);
			mismatch_count++;
		end
	endtask

	task automatic check_count(input string name, input int want, input int got);
		if (got !== want) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, want, got);
			mismatch_count++;
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	// Lines starting with # are skipped to end of line
	task automatic read_trace(output bit ok);
		int          fd;
		int          n;
		int          c;
		string       tok;
		logic [31:0] op_v;
		logic [31:0] a_v;
		logic [31:0] b_v;
		logic [31:0] y_v;
		ok = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open trace file %s", TRACE_FILE);
		end else begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", tok);
				if (n == 1) begin
					if (tok[0] == "#") begin
						c = $fgetc(fd);
						while (c != "\n" && c != -1)
							c = $fgetc(fd);
					end else begin
						n = $fscanf(fd, "%h %h %h %h", op_v, a_v, b_v, y_v);
						if (n != 4) begin
							$display("Trace line %s does not hold four hex fields", tok);
							ok = 1'b0;
						end else begin
							trace_name.push_back(tok);
							trace_op.push_back(fpalu_pkg::alu_op_e'(op_v[0]));
							trace_a.push_back(fpalu_pkg::fp29_t'(a_v[28:0]));
							trace_b.push_back(fpalu_pkg::fp29_t'(b_v[28:0]));
							trace_y.push_back(fpalu_pkg::fp29_t'(y_v[28:0]));
						end
					end
				end
			end
			$fclose(fd);
			if (trace_name.size() == 0) begin
				$display("Trace file %s holds no operations", TRACE_FILE);
				ok = 1'b0;
			end
		end
	endtask

	// Called DRIVE_DLY after an edge
	task automatic issue_op(input int idx);
		in_valid = 1'b1;
		op       = trace_op[idx];
		a        = trace_a[idx];
		b        = trace_b[idx];
		exp_name_q.push_back(trace_name[idx]);
		exp_y_q.push_back(trace_y[idx]);
		exp_cycle_q.push_back(cycle);
	endtask

	task automatic run_trace();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY rst_n = 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			gap = $unsigned($random(seed)) % 3;  // 0 to 2 idle cycles
			repeat (gap) begin
				@(posedge clk);
				#DRIVE_DLY in_valid = 1'b0;
			end
			@(posedge clk);
			#DRIVE_DLY;
			issue_op(i);
		end
		@(posedge clk);
		#DRIVE_DLY in_valid = 1'b0;
		wait (result_count >= n_lines);
		repeat (LATENCY) @(posedge clk);  // Room for any stray result
		check_count("result count", n_lines, result_count);
	endtask

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		op       = fpalu_pkg::OP_ADD;
		a        = '0;
		b        = '0;
		read_trace(loaded);
		if (!loaded) begin
			other_errors++;
			finish_run();
		end else begin
			n_lines      = trace_name.size();
			trace_loaded = 1'b1;
			run_trace();
			finish_run();
		end
	end

	// Outputs settle after posedge, so look at negedge
	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			if (exp_y_q.size() == 0) begin
				$display("Result %h arrived at cycle %0d with no operation outstanding", y, cycle);
				other_errors++;
			end else begin
				got_name  = exp_name_q.pop_front();
				want_y    = exp_y_q.pop_front();
				issued_at = exp_cycle_q.pop_front();
				check_result(got_name, want_y, y);
				check_count({got_name, " latency"}, LATENCY, cycle - issued_at);
			end
			result_count++;
		end else if (out_valid !== 1'b0) begin
			$display("out_valid is unknown at cycle %0d", cycle);
			other_errors++;
		end
	end

	// Worst case per line is two idle cycles plus the issue
	initial begin
		wait (trace_loaded);
		repeat (n_lines * 3 + 20) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d results received",
			n_lines * 3 + 20, result_count, n_lines);
		other_errors++;
		finish_run();
	end

endmodule

// ==== source/fpalu_top.sv ====
`timescale 1ns/100ps

module fpalu_top #(
	parameter int PP_COUNT = fpalu_pkg::PP_COUNT
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  fpalu_pkg::alu_op_e op,
	input  fpalu_pkg::fp29_t   a,
	input  fpalu_pkg::fp29_t   b,
	output logic               out_valid,
	output fpalu_pkg::fp29_t   y
);

	logic                    add_in_valid;
	logic                    mul_in_valid;
	logic                    add_valid;
	logic                    mul_valid;
	fpalu_pkg::align_stage_t add_data;
	fpalu_pkg::mul_stage_t   mul_data;
	logic                    sum_valid;
	fpalu_pkg::sum_stage_t   sum_d;
	logic                    sum_q_valid;
	fpalu_pkg::sum_stage_t   sum_q;

	// Only one path takes each issue
	assign add_in_valid = in_valid & (op == fpalu_pkg::OP_ADD);
	assign mul_in_valid = in_valid & (op == fpalu_pkg::OP_MUL);

	add_align u_add_align (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (add_in_valid),
		.a        (a),
		.b        (b),
		.out_valid(add_valid),
		.out_data (add_data)
	);

	booth_mul #(.PP_COUNT(PP_COUNT)) u_booth_mul (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (mul_in_valid),
		.a        (a),
		.b        (b),
		.out_valid(mul_valid),
		.out_data (mul_data)
	);

	shared_adder u_shared_adder (
		.add_valid(add_valid),
		.add_data (add_data),
		.mul_valid(mul_valid),
		.mul_data (mul_data),
		.sum_valid(sum_valid),
		.sum_data (sum_d)
	);

	// Stage 3 register
	pipe_reg #(.payload_t(fpalu_pkg::sum_stage_t)) u_sum_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (sum_valid),
		.in_data  (sum_d),
		.out_valid(sum_q_valid),
		.out_data (sum_q)
	);

	normalize u_normalize (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (sum_q_valid),
		.in_data  (sum_q),
		.out_valid(out_valid),
		.y        (y)
	);

endmodule

// ==== source/normalize.sv ====
`timescale 1ns/100ps

module normalize (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  fpalu_pkg::sum_stage_t in_data,
	output logic                  out_valid,
	output fpalu_pkg::fp29_t      y
);

	localparam int MAN_W = fpalu_pkg::MAN_W;
	localparam int EXP_W = fpalu_pkg::EXP_W;
	localparam int LZ_W  = $clog2(MAN_W + 1);

	typedef struct packed {
		logic [MAN_W:0]   mag;     // Bit MAN_W is the add carry
		logic [LZ_W-1:0]  lzc;     // Zeros above the top one, in 22 bits
		logic [EXP_W-1:0] exp;
		logic             sign;
		logic             bypass;
	} lz_t;

	logic             neg;
	logic [MAN_W+1:0] abs_sum;
	lz_t              lz_d;
	lz_t              lz_q;
	logic             lz_valid;
	fpalu_pkg::fp29_t y_d;

	// Stage 4
	always_comb begin
		neg       = in_data.sum[MAN_W+1] & ~in_data.bypass;
		abs_sum   = neg ? -in_data.sum : in_data.sum;
		lz_d.mag  = abs_sum[MAN_W:0];
		lz_d.lzc  = LZ_W'(MAN_W);  // All zero
		for (int i = 0; i < MAN_W; i++) begin
			if (abs_sum[i])
				lz_d.lzc = LZ_W'(MAN_W - 1 - i);  // Highest one wins
		end
		lz_d.exp    = in_data.exp;
		lz_d.sign   = in_data.sign ^ neg;  // Smaller operand was larger
		lz_d.bypass = in_data.bypass;
	end

	pipe_reg #(.payload_t(lz_t)) u_lz_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_data  (lz_d),
		.out_valid(lz_valid),
		.out_data (lz_q)
	);

	// Stage 5
	always_comb begin
		y_d.sign = lz_q.sign;
		y_d.exp  = lz_q.exp;
		y_d.man  = lz_q.mag[MAN_W-1:0];  // Bypass operand as is
		if (!lz_q.bypass) begin
			if (lz_q.mag == '0) begin
				y_d = '0;
			end else if (lz_q.mag[MAN_W]) begin
				y_d.man = lz_q.mag[MAN_W:1];  // Carry out, drop the lsb
				y_d.exp = lz_q.exp + 1'b1;
			end else begin
				y_d.man = lz_q.mag[MAN_W-1:0] << lz_q.lzc;
				y_d.exp = lz_q.exp - EXP_W'(lz_q.lzc);
			end
		end
	end

	pipe_reg #(.payload_t(fpalu_pkg::fp29_t)) u_out_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (lz_valid),
		.in_data  (y_d),
		.out_valid(out_valid),
		.out_data (y)
	);

endmodule

// ==== source/shared_adder.sv ====
`timescale 1ns/100ps

module shared_adder (
	input  logic                    add_valid,
	input  fpalu_pkg::align_stage_t add_data,
	input  logic                    mul_valid,
	input  fpalu_pkg::mul_stage_t   mul_data,
	output logic                    sum_valid,
	output fpalu_pkg::sum_stage_t   sum_data
);

	localparam int MAN_W = fpalu_pkg::MAN_W;
	localparam int W     = MAN_W + 2;  // Signed 24-bit sum

	logic [W-1:0] lhs;
	logic [W-1:0] rhs;
	logic         cin;
	logic [W-1:0] g;
	logic [W-1:0] p;
	logic [W-1:0] gk;
	logic [W-1:0] pk;
	logic [W-1:0] gn;
	logic [W-1:0] pn;
	logic [W-1:0] sum;

	// Operand mux
	always_comb begin
		if (add_valid) begin
			lhs = {add_data.lhs[MAN_W], add_data.lhs};  // Sign extend
			rhs = {add_data.rhs[MAN_W], add_data.rhs};
			cin = add_data.sub;  // Completes the two's complement
		end else begin
			lhs = W'(mul_data.row0);
			rhs = W'({mul_data.row1, {fpalu_pkg::PP_COUNT{1'b0}}});
			cin = 1'b0;
		end
	end

	assign g = lhs & rhs;
	assign p = lhs ^ rhs;

	// Kogge-Stone carry lookahead
	always_comb begin
		gk    = g;
		pk    = p;
		gk[0] = g[0] | (p[0] & cin);  // Fold carry-in
		gn    = gk;
		pn    = pk;
		for (int d = 1; d < W; d = d * 2) begin
			gn = gk;
			pn = pk;
			for (int i = d; i < W; i++) begin
				gn[i] = gk[i] | (pk[i] & gk[i-d]);
				pn[i] = pk[i] & pk[i-d];
			end
			gk = gn;
			pk = pn;
		end
		sum = p ^ {gk[W-2:0], cin};
	end

	assign sum_valid = add_valid | mul_valid;

	always_comb begin
		if (add_valid) begin
			sum_data.sum    = add_data.bypass ? W'(add_data.lhs) : sum;
			sum_data.exp    = add_data.exp;
			sum_data.sign   = add_data.sign;
			sum_data.bypass = add_data.bypass;
		end else begin
			sum_data.sum    = {2'b00, sum[MAN_W-1:0]};  // Rows wrap mod 2^22
			sum_data.exp    = mul_data.exp;
			sum_data.sign   = mul_data.sign;
			sum_data.bypass = 1'b0;
		end
	end

endmodule

// ==== source/booth_mul.sv ====
`timescale 1ns/100ps

module booth_mul #(
	parameter int PP_COUNT = fpalu_pkg::PP_COUNT
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  fpalu_pkg::fp29_t      a,
	input  fpalu_pkg::fp29_t      b,
	output logic                  out_valid,
	output fpalu_pkg::mul_stage_t out_data
);

	localparam int HMAN_W = fpalu_pkg::HMAN_W;
	localparam int HEXP_W = fpalu_pkg::HEXP_W;
	localparam int EXP_W  = fpalu_pkg::EXP_W;
	localparam int PP_W   = fpalu_pkg::PP_W;
	localparam int ROW0_W = fpalu_pkg::ROW0_W;
	localparam int ROW1_W = fpalu_pkg::ROW1_W;
	localparam int SIG_W  = HMAN_W + 1;
	localparam int HALF   = PP_COUNT / 2;  // PPs per row
	// FP16 product scale rebased onto the FP29i offset
	localparam int EXP_OFS = fpalu_pkg::EXP_BIAS29 - 2 * (fpalu_pkg::HEXP_BIAS + HMAN_W);

	typedef struct packed {
		logic [PP_COUNT-1:0][PP_W-1:0] pp;
		logic [PP_COUNT-1:0]           neg;
		logic [HEXP_W-1:0]             ea;
		logic [HEXP_W-1:0]             eb;
		logic                          sa;
		logic                          sb;
	} pp_t;

	logic [SIG_W-1:0]              sig_a;
	logic [SIG_W-1:0]              sig_b;
	logic [HEXP_W-1:0]             ea;
	logic [HEXP_W-1:0]             eb;
	logic [2*PP_COUNT:0]           b_ext;
	logic [PP_COUNT-1:0][PP_W-1:0] pp;
	logic [PP_COUNT-1:0]           neg;
	pp_t                           pp_d;
	pp_t                           pp_q;
	logic                          pp_valid;
	logic [ROW0_W-1:0]             row0;
	logic [ROW1_W-1:0]             row1;
	fpalu_pkg::mul_stage_t         mul_d;

	// Hidden one unless denormal; denormal exponent reads as 1
	assign sig_a = {|a.exp[HEXP_W-1:0], a.man[HMAN_W-1:0]};
	assign sig_b = {|b.exp[HEXP_W-1:0], b.man[HMAN_W-1:0]};
	assign ea    = (|a.exp[HEXP_W-1:0]) ? a.exp[HEXP_W-1:0] : HEXP_W'(1);
	assign eb    = (|b.exp[HEXP_W-1:0]) ? b.exp[HEXP_W-1:0] : HEXP_W'(1);
	assign b_ext = {{(2 * PP_COUNT - SIG_W){1'b0}}, sig_b, 1'b0};  // Unsigned, implicit b[-1]

	genvar gi;
	generate
		for (gi = 0; gi < PP_COUNT; gi++) begin : g_pp
			logic [2:0]      trip;
			logic            one;
			logic            two;
			logic [PP_W-1:0] mag;
			assign trip    = b_ext[2*gi+2 -: 3];
			assign one     = trip[1] ^ trip[0];                    // Digit +-1
			assign two     = (trip == 3'b011) | (trip == 3'b100);  // Digit +-2
			assign mag     = one ? PP_W'(sig_a) : (two ? PP_W'({sig_a, 1'b0}) : '0);
			assign neg[gi] = trip[2] & ~(trip[1] & trip[0]);       // 111 is plus zero
			assign pp[gi]  = mag ^ {PP_W{neg[gi]}};                // +1 added in reduction
		end
	endgenerate

	always_comb begin
		pp_d.pp  = pp;
		pp_d.neg = neg;
		pp_d.ea  = ea;
		pp_d.eb  = eb;
		pp_d.sa  = a.sign;
		pp_d.sb  = b.sign;
	end

	pipe_reg #(.payload_t(pp_t)) u_pp_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_data  (pp_d),
		.out_valid(pp_valid),
		.out_data (pp_q)
	);

	// Stage 2, low PPs into row0, high PPs into row1
	// Each PP gets ~s at bit PP_W; the matching 2^PP_W offsets come off row1
	always_comb begin
		row0 = '0;
		row1 = '0;
		for (int i = 0; i < PP_COUNT; i++) begin
			if (i < HALF) begin
				row0 = row0 + (ROW0_W'({~pp_q.neg[i], pp_q.pp[i]} + pp_q.neg[i]) << (2 * i));
				row1 = row1 - (ROW1_W'(1) << (PP_W + 2 * i - 2 * HALF));
			end else begin
				row1 = row1 + (ROW1_W'({~pp_q.neg[i], pp_q.pp[i]} + pp_q.neg[i]) << (2 * (i - HALF)));
				row1 = row1 - (ROW1_W'(1) << (PP_W + 2 * (i - HALF)));
			end
		end
	end

	always_comb begin
		mul_d.row0 = row0;
		mul_d.row1 = row1;
		mul_d.sign = pp_q.sa ^ pp_q.sb;
		mul_d.exp  = EXP_W'(pp_q.ea) + EXP_W'(pp_q.eb) + EXP_W'(EXP_OFS);  // ea + eb + 2
	end

	pipe_reg #(.payload_t(fpalu_pkg::mul_stage_t)) u_row_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (pp_valid),
		.in_data  (mul_d),
		.out_valid(out_valid),
		.out_data (out_data)
	);

endmodule

// ==== source/add_align.sv ====
`timescale 1ns/100ps

module add_align (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  fpalu_pkg::fp29_t        a,
	input  fpalu_pkg::fp29_t        b,
	output logic                    out_valid,
	output fpalu_pkg::align_stage_t out_data
);

	localparam int MAN_W = fpalu_pkg::MAN_W;
	localparam int EXP_W = fpalu_pkg::EXP_W;
	localparam int SH_W  = $clog2(MAN_W);  // Shifter levels

	typedef struct packed {
		logic [MAN_W-1:0] man_l;   // Larger exponent leads
		logic [MAN_W-1:0] man_s;
		logic [EXP_W-1:0] exp_l;
		logic [EXP_W-1:0] exp_s;
		logic             sign_l;
		logic             sign_s;
		logic [EXP_W-1:0] shamt;   // Exponent difference
		logic             zero_l;
		logic             zero_s;
	} cmp_t;

	logic [EXP_W:0]          diff;
	logic                    b_lead;
	cmp_t                    cmp_d;
	cmp_t                    cmp_q;
	logic                    cmp_valid;
	logic [MAN_W-1:0]        shifted;
	fpalu_pkg::align_stage_t aln_d;

	// Stage 1
	assign diff   = {1'b0, a.exp} - {1'b0, b.exp};
	assign b_lead = diff[EXP_W];  // Borrow out, eb above ea

	always_comb begin
		cmp_d.man_l  = b_lead ? b.man : a.man;   // Swap on borrow
		cmp_d.man_s  = b_lead ? a.man : b.man;
		cmp_d.exp_l  = b_lead ? b.exp : a.exp;
		cmp_d.exp_s  = b_lead ? a.exp : b.exp;
		cmp_d.sign_l = b_lead ? b.sign : a.sign;
		cmp_d.sign_s = b_lead ? a.sign : b.sign;
		cmp_d.shamt  = b_lead ? -diff[EXP_W-1:0] : diff[EXP_W-1:0];
		cmp_d.zero_l = ~|cmp_d.man_l;
		cmp_d.zero_s = ~|cmp_d.man_s;
	end

	pipe_reg #(.payload_t(cmp_t)) u_cmp_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_data  (cmp_d),
		.out_valid(cmp_valid),
		.out_data (cmp_q)
	);

	// Stage 2, log barrel shifter
	always_comb begin
		shifted = cmp_q.man_s;
		for (int k = 0; k < SH_W; k++) begin
			if (cmp_q.shamt[k])
				shifted = shifted >> (1 << k);
		end
		if (cmp_q.shamt >= EXP_W'(MAN_W))
			shifted = '0;  // Everything shifted out
	end

	always_comb begin
		aln_d.sub    = cmp_q.sign_l ^ cmp_q.sign_s;
		aln_d.bypass = cmp_q.zero_l | cmp_q.zero_s;
		aln_d.lhs    = {1'b0, cmp_q.man_l};
		aln_d.rhs    = aln_d.sub ? ~{1'b0, shifted} : {1'b0, shifted};  // One's complement
		aln_d.exp    = cmp_q.exp_l;
		aln_d.sign   = cmp_q.sign_l;
		// Survivor rides in lhs untouched
		if (aln_d.bypass) begin
			aln_d.rhs = '0;
			if (!cmp_q.zero_s) begin
				aln_d.lhs  = {1'b0, cmp_q.man_s};
				aln_d.exp  = cmp_q.exp_s;
				aln_d.sign = cmp_q.sign_s;
			end
		end
	end

	pipe_reg #(.payload_t(fpalu_pkg::align_stage_t)) u_aln_reg (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (cmp_valid),
		.in_data  (aln_d),
		.out_valid(out_valid),
		.out_data (out_data)
	);

endmodule

// ==== source/pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload holds when idle, saves toggling
	always_ff @(posedge clk) begin
		if (in_valid)
			out_data <= in_data;
	end

endmodule

// ==== source/fpalu_pkg.sv ====
package fpalu_pkg;

	// FP29i: (-1)^sign * man * 2^(exp - 52), mantissa kept unnormalized on input
	localparam int MAN_W      = 22;
	localparam int EXP_W      = 6;
	localparam int EXP_BIAS29 = 52;

	// FP16 fields as seen in the low bits of an operand
	localparam int HMAN_W    = 10;
	localparam int HEXP_W    = 5;
	localparam int HEXP_BIAS = 15;

	// Radix-4 Booth over an 11-bit significand
	localparam int PP_COUNT = 6;
	localparam int PP_W     = 12;  // Significand times two

	// Reduced rows; row1 sits PP_COUNT bits up
	localparam int ROW0_W = PP_W + PP_COUNT;
	localparam int ROW1_W = 2 * (HMAN_W + 1) - PP_COUNT;

	typedef enum logic {
		OP_ADD = 1'b0,
		OP_MUL = 1'b1
	} alu_op_e;

	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fp29_t;

	// Add path after alignment
	typedef struct packed {
		logic [MAN_W:0]   lhs;     // Larger-exponent mantissa, or bypass operand
		logic [MAN_W:0]   rhs;     // Aligned and, for subtract, inverted
		logic             sub;     // Signs differ, adder carry-in
		logic             bypass;  // One mantissa was zero
		logic [EXP_W-1:0] exp;
		logic             sign;    // Sign of larger-exponent operand
	} align_stage_t;

	// Multiply path after row reduction
	typedef struct packed {
		logic [ROW0_W-1:0] row0;
		logic [ROW1_W-1:0] row1;
		logic              sign;
		logic [EXP_W-1:0]  exp;  // Raw, before normalize
	} mul_stage_t;

	typedef struct packed {
		logic [MAN_W+1:0] sum;     // Signed sum, or bypass operand zero-extended
		logic [EXP_W-1:0] exp;
		logic             sign;    // Reference sign before correction
		logic             bypass;
	} sum_stage_t;

endpackage
